/* hdl/interrupt_ctrl.sv */
`default_nettype none

module interrupt_ctrl import mcu_pkg::*; (
  input  logic          clk,
  input  logic          reset_n,
  input  logic [7:0]    clock_count,
  timer_ctrl_if.monitor events,
  irq_if.ctrl           regs,
  output logic [2:0]    irq
);

  clk_factor_t cur_bits;
  clk_factor_t prev_bits;
  clk_factor_t clk_fall;
  clk_factor_t clk_factor;
  sw_factor_t  sw_factor;
  logic        pt_factor;
  logic [2:0]  pending;

  // 32, 8, 2 and 1 Hz taps of the clock timer
  assign cur_bits = {clock_count[7], clock_count[6], clock_count[4], clock_count[2]};
  assign clk_fall = prev_bits & ~cur_bits;

  assign pending = {
    pt_factor & regs.pt_mask,
    |(sw_factor & regs.sw_mask),
    |(clk_factor & regs.clk_mask)
  };

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      prev_bits  <= '0;
      clk_factor <= '0;
      sw_factor  <= '0;
      pt_factor  <= 1'b0;
      irq        <= '0;
    end else begin
      prev_bits <= cur_bits;
      // New events land even on a clear cycle
      clk_factor <= (regs.clear_clk ? clk_factor_t'(0) : clk_factor) | clk_fall;
      sw_factor  <= (regs.clear_sw ? sw_factor_t'(0) : sw_factor) | events.sw_event;
      pt_factor  <= (regs.clear_pt ? 1'b0 : pt_factor) | events.pt_event;
      irq        <= pending;
    end
  end

  assign regs.clk_factor = clk_factor;
  assign regs.sw_factor  = sw_factor;
  assign regs.pt_factor  = pt_factor;

  // A request line only rises behind an unmasked factor
  a_irq_cause: assert property (@(posedge clk) disable iff (!reset_n)
    (!irq[0] || $past(|(clk_factor & regs.clk_mask))) &&
    (!irq[1] || $past(|(sw_factor & regs.sw_mask))) &&
    (!irq[2] || $past(pt_factor && regs.pt_mask)));

endmodule

`default_nettype wire

/* hdl/io_regs.sv */
`default_nettype none

`include "mcu_defs.svh"

module io_regs import mcu_pkg::*; (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          write_en,
  input  logic [11:0]   addr,
  input  logic [3:0]    write_data,
  output logic [3:0]    read_data,
  input  timer_status_t status,
  timer_ctrl_if.ctrl    tctl,
  irq_if.regs           iregs
);

  logic [3:0] ram [`MCU_RAM_WORDS];

  logic       is_ram;
  logic       is_io;
  logic       rd_io;
  logic [7:0] io_off;
  logic [3:0] rd_next;

  clk_factor_t clk_mask;
  sw_factor_t  sw_mask;
  logic        pt_mask;
  logic [7:0]  reload;
  pt_src_t     pt_src;
  logic [2:0]  svd;
  logic        enable_sw;
  logic        enable_pt;
  logic        reset_clock;
  logic        reset_sw;
  logic        reset_pt;

  assign is_ram  = (addr < `MCU_RAM_END);
  assign is_io   = (addr[11:8] == `MCU_IO_PAGE);
  assign io_off  = addr[7:0];
  assign rd_io   = !write_en && is_io;

  // Factor reads clear on the same edge that captures the old value
  assign iregs.clear_clk = rd_io && (io_off == `REG_CLK_FACTOR);
  assign iregs.clear_sw  = rd_io && (io_off == `REG_SW_FACTOR);
  assign iregs.clear_pt  = rd_io && (io_off == `REG_PT_FACTOR);

  always_ff @(posedge clk) begin
    if (write_en && is_ram) begin
      ram[addr[9:0]] <= write_data;
    end
  end

  // Display windows and unmapped space fall through to zero
  always_comb begin
    rd_next = '0;
    if (!write_en) begin
      if (is_ram) begin
        rd_next = ram[addr[9:0]];
      end else if (is_io) begin
        case (io_off)
          `REG_CLK_FACTOR: rd_next = iregs.clk_factor;
          `REG_SW_FACTOR:  rd_next = {2'b00, iregs.sw_factor};
          `REG_PT_FACTOR:  rd_next = {3'b000, iregs.pt_factor};
          `REG_CLK_MASK:   rd_next = clk_mask;
          `REG_SW_MASK:    rd_next = {2'b00, sw_mask};
          `REG_PT_MASK:    rd_next = {3'b000, pt_mask};
          `REG_CLK_LO:     rd_next = status.clock_count[3:0];
          `REG_CLK_HI:     rd_next = status.clock_count[7:4];
          `REG_SW_LO:      rd_next = status.swl;
          `REG_SW_HI:      rd_next = status.swh;
          `REG_PT_LO:      rd_next = status.pt_count[3:0];
          `REG_PT_HI:      rd_next = status.pt_count[7:4];
          `REG_RELOAD_LO:  rd_next = reload[3:0];
          `REG_RELOAD_HI:  rd_next = reload[7:4];
          `REG_PT_SEL:     rd_next = {2'b00, pt_src};
          // Battery always reported good
          `REG_SVD:        rd_next = {1'b1, svd};
          `REG_SW_CTRL:    rd_next = {3'b000, enable_sw};
          `REG_PT_CTRL:    rd_next = {3'b000, enable_pt};
          default:         rd_next = '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      clk_mask    <= '0;
      sw_mask     <= '0;
      pt_mask     <= 1'b0;
      reload      <= '0;
      pt_src      <= PT_SRC_256;
      svd         <= '0;
      enable_sw   <= 1'b0;
      enable_pt   <= 1'b0;
      reset_clock <= 1'b0;
      reset_sw    <= 1'b0;
      reset_pt    <= 1'b0;
      read_data   <= '0;
    end else begin
      reset_clock <= 1'b0;
      reset_sw    <= 1'b0;
      reset_pt    <= 1'b0;
      read_data   <= rd_next;
      if (write_en && is_io) begin
        case (io_off)
          `REG_CLK_MASK:    clk_mask <= write_data;
          `REG_SW_MASK:     sw_mask <= write_data[1:0];
          `REG_PT_MASK:     pt_mask <= write_data[0];
          `REG_RELOAD_LO:   reload[3:0] <= write_data;
          `REG_RELOAD_HI:   reload[7:4] <= write_data;
          `REG_PT_SEL:      pt_src <= pt_src_t'(write_data[1:0]);
          `REG_SVD:         svd <= write_data[2:0];
          // Bit 0 would be the watchdog, not present here
          `REG_TIMER_RESET: reset_clock <= write_data[1];
          `REG_SW_CTRL:     {reset_sw, enable_sw} <= write_data[1:0];
          `REG_PT_CTRL:     {reset_pt, enable_pt} <= write_data[1:0];
          default: ;
        endcase
      end
    end
  end

  assign tctl.reset_clock      = reset_clock;
  assign tctl.reset_stopwatch  = reset_sw;
  assign tctl.reset_prog       = reset_pt;
  assign tctl.enable_stopwatch = enable_sw;
  assign tctl.enable_prog      = enable_pt;
  assign tctl.pt_src           = pt_src;
  assign tctl.reload           = reload;

  assign iregs.clk_mask = clk_mask;
  assign iregs.sw_mask  = sw_mask;
  assign iregs.pt_mask  = pt_mask;

  a_rd_after_wr: assert property (@(posedge clk) disable iff (!reset_n)
    write_en |=> (read_data == 4'd0));

endmodule

`default_nettype wire

/* hdl/mcu_defs.svh */
`ifndef MCU_DEFS_SVH
`define MCU_DEFS_SVH

// Data memory map
`define MCU_RAM_WORDS 640
`define MCU_RAM_END 12'h280
`define MCU_IO_PAGE 4'hF

// Display segment windows, no storage behind them
`define MCU_DISP_LO_START 12'hE00
`define MCU_DISP_LO_END 12'hE50
`define MCU_DISP_HI_START 12'hE80
`define MCU_DISP_HI_END 12'hED0

// I/O register offsets inside page 0xF
`define REG_CLK_FACTOR 8'h00
`define REG_SW_FACTOR 8'h01
`define REG_PT_FACTOR 8'h02
`define REG_CLK_MASK 8'h10
`define REG_SW_MASK 8'h11
`define REG_PT_MASK 8'h12
`define REG_CLK_LO 8'h20
`define REG_CLK_HI 8'h21
`define REG_SW_LO 8'h22
`define REG_SW_HI 8'h23
`define REG_PT_LO 8'h24
`define REG_PT_HI 8'h25
`define REG_RELOAD_LO 8'h26
`define REG_RELOAD_HI 8'h27
`define REG_PT_SEL 8'h28
`define REG_SVD 8'h73
`define REG_TIMER_RESET 8'h76
`define REG_SW_CTRL 8'h77
`define REG_PT_CTRL 8'h78

// Timebase dividers in clk cycles
`define TICK_DIV 8
`define SW_DIV 20

`endif

/* hdl/mcu_ifs.sv */
`default_nettype none

// Timer control from the register block, plus event pulses back out
interface timer_ctrl_if import mcu_pkg::*; ();
  logic       reset_clock;
  logic       reset_stopwatch;
  logic       reset_prog;
  logic       enable_stopwatch;
  logic       enable_prog;
  pt_src_t    pt_src;
  logic [7:0] reload;
  sw_factor_t sw_event;
  logic       pt_event;

  modport ctrl (
    output reset_clock, reset_stopwatch, reset_prog,
    output enable_stopwatch, enable_prog, pt_src, reload
  );

  modport timer (
    input  reset_clock, reset_stopwatch, reset_prog,
    input  enable_stopwatch, enable_prog, pt_src, reload,
    output sw_event, pt_event
  );

  // Interrupt side only watches the event pulses
  modport monitor (input sw_event, pt_event);
endinterface

// Masks and factor clears out of the register block, factors back in
interface irq_if import mcu_pkg::*; ();
  clk_factor_t clk_mask;
  sw_factor_t  sw_mask;
  logic        pt_mask;
  logic        clear_clk;
  logic        clear_sw;
  logic        clear_pt;
  clk_factor_t clk_factor;
  sw_factor_t  sw_factor;
  logic        pt_factor;

  modport regs (
    output clk_mask, sw_mask, pt_mask, clear_clk, clear_sw, clear_pt,
    input  clk_factor, sw_factor, pt_factor
  );

  modport ctrl (
    input  clk_mask, sw_mask, pt_mask, clear_clk, clear_sw, clear_pt,
    output clk_factor, sw_factor, pt_factor
  );
endinterface

`default_nettype wire

/* hdl/mcu_periph_top.sv */
`default_nettype none

module mcu_periph_top import mcu_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        mem_write_en,
  input  logic [11:0] mem_addr,
  input  logic [3:0]  mem_write_data,
  output logic [3:0]  mem_read_data,
  output logic [2:0]  irq
);

  timer_ctrl_if u_timer_ctrl_if ();
  irq_if        u_irq_if ();

  timer_status_t status;

  // CPU facing bus decoder and register file
  io_regs u_io_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .write_en   (mem_write_en),
    .addr       (mem_addr),
    .write_data (mem_write_data),
    .read_data  (mem_read_data),
    .status     (status),
    .tctl       (u_timer_ctrl_if.ctrl),
    .iregs      (u_irq_if.regs)
  );

  timers u_timers (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl    (u_timer_ctrl_if.timer),
    .status  (status)
  );

  // Clock factors come from edges of the free running count
  interrupt_ctrl u_interrupt_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .clock_count (status.clock_count),
    .events      (u_timer_ctrl_if.monitor),
    .regs        (u_irq_if.ctrl),
    .irq         (irq)
  );

endmodule

`default_nettype wire

/* hdl/mcu_pkg.sv */
`default_nettype none

package mcu_pkg;

  // Snapshot of all timer counters, read through the I/O page
  typedef struct packed {
    logic [7:0] clock_count;
    logic [3:0] swl;
    logic [3:0] swh;
    logic [7:0] pt_count;
  } timer_status_t;

  // Bit 0 = 32 Hz, bit 1 = 8 Hz, bit 2 = 2 Hz, bit 3 = 1 Hz falling edge
  typedef logic [3:0] clk_factor_t;

  // Bit 0 = 10 Hz, bit 1 = 1 Hz
  typedef logic [1:0] sw_factor_t;

  // Programmable timer step rate, derived from the 256 Hz counter
  typedef enum logic [1:0] {
    PT_SRC_256 = 2'd0,
    PT_SRC_64  = 2'd1,
    PT_SRC_16  = 2'd2,
    PT_SRC_4   = 2'd3
  } pt_src_t;

endpackage

`default_nettype wire

/* hdl/timers.sv */
`default_nettype none

`include "mcu_defs.svh"

module timers import mcu_pkg::*; (
  input  logic          clk,
  input  logic          reset_n,
  timer_ctrl_if.timer   ctrl,
  output timer_status_t status
);

  localparam int tick_w = $clog2(`TICK_DIV);
  localparam int sw_w = $clog2(`SW_DIV);

  logic [tick_w-1:0] tick_cnt;
  logic              tick;
  logic [7:0]        clock_count;

  logic [sw_w-1:0] sw_cnt;
  logic            sw_step;
  logic [3:0]      swl;
  logic [3:0]      swh;
  sw_factor_t      sw_evt;

  logic       src_hit;
  logic       pt_step;
  logic [7:0] pt_count;
  logic       pt_evt;

  // 256 Hz timebase, restarted by the clock timer reset
  assign tick = (tick_cnt == tick_w'(`TICK_DIV - 1));

  always_ff @(posedge clk) begin
    if (!reset_n || ctrl.reset_clock) begin
      tick_cnt    <= '0;
      clock_count <= '0;
    end else begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      if (tick) begin
        clock_count <= clock_count + 1'b1;
      end
    end
  end

  // Stopwatch runs its own 100 Hz divider, only while enabled
  assign sw_step = ctrl.enable_stopwatch && (sw_cnt == sw_w'(`SW_DIV - 1));

  always_ff @(posedge clk) begin
    if (!reset_n || ctrl.reset_stopwatch) begin
      sw_cnt <= '0;
      swl    <= '0;
      swh    <= '0;
      sw_evt <= '0;
    end else begin
      sw_evt <= '0;
      if (ctrl.enable_stopwatch) begin
        sw_cnt <= sw_step ? '0 : sw_cnt + 1'b1;
      end
      if (sw_step) begin
        if (swl == 4'd9) begin
          swl       <= '0;
          sw_evt[0] <= 1'b1;
          if (swh == 4'd9) begin
            swh       <= '0;
            sw_evt[1] <= 1'b1;
          end else begin
            swh <= swh + 1'b1;
          end
        end else begin
          swl <= swl + 1'b1;
        end
      end
    end
  end

  // Slower rates step when the low counter bits roll over
  always_comb begin
    src_hit = 1'b0;
    case (ctrl.pt_src)
      PT_SRC_256: src_hit = 1'b1;
      PT_SRC_64:  src_hit = (clock_count[1:0] == 2'd0);
      PT_SRC_16:  src_hit = (clock_count[3:0] == 4'd0);
      PT_SRC_4:   src_hit = (clock_count[5:0] == 6'd0);
    endcase
  end

  assign pt_step = tick && src_hit;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      pt_count <= '0;
      pt_evt   <= 1'b0;
    end else begin
      pt_evt <= 1'b0;
      if (ctrl.reset_prog) begin
        pt_count <= ctrl.reload;
      end else if (ctrl.enable_prog) begin
        if (pt_count == 8'd0) begin
          // Started from an empty counter
          pt_count <= ctrl.reload;
        end else if (pt_step) begin
          if (pt_count == 8'd1) begin
            pt_count <= ctrl.reload;
            pt_evt   <= 1'b1;
          end else begin
            pt_count <= pt_count - 1'b1;
          end
        end
      end
    end
  end

  assign ctrl.sw_event = sw_evt;
  assign ctrl.pt_event = pt_evt;

  assign status = '{clock_count: clock_count, swl: swl, swh: swh, pt_count: pt_count};

  a_sw_bcd: assert property (@(posedge clk) disable iff (!reset_n)
    (swl <= 4'd9) && (swh <= 4'd9));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_periph -o tb_periph
./obj_dir/tb_periph | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
else
  exit 1
fi

/* sources.f */
+incdir+hdl
hdl/mcu_pkg.sv
hdl/mcu_ifs.sv
hdl/timers.sv
hdl/interrupt_ctrl.sv
hdl/io_regs.sv
hdl/mcu_periph_top.sv
test/tb_periph.sv

/* test/tb_periph.sv */
`default_nettype none

`include "mcu_defs.svh"

module tb_periph import mcu_pkg::*; ;
  localparam logic [11:0] idle_addr = 12'h300;

  logic clk = 1'b0;
  logic reset_n = 1'b0;
  logic mem_write_en = 1'b0;
  logic [11:0] mem_addr = idle_addr;
  logic [3:0] mem_write_data = 4'h0;
  logic [3:0] mem_read_data;
  logic [2:0] irq;

  // Shadow copy of the CPU-visible state
  logic [3:0] shadow_ram [`MCU_RAM_WORDS];
  logic [3:0] sh_clk_mask = '0;
  logic [1:0] sh_sw_mask = '0;
  logic sh_pt_mask = 1'b0;
  logic [7:0] sh_reload = '0;
  logic [1:0] sh_pt_src = '0;
  logic [2:0] sh_svd = '0;
  logic sh_sw_en = 1'b0;
  logic sh_pt_en = 1'b0;

  // Read issued on the bus, picked up by the compare process
  logic rd_issued = 1'b0;
  logic rd_check = 1'b0;
  logic [11:0] rd_addr = '0;
  logic [3:0] rd_exp = '0;

  int error_count = 0;
  int check_count = 0;
  int failed_tests = 0;
  int err_mark = 0;

  mcu_periph_top u_dut (
    .clk            (clk),
    .reset_n        (reset_n),
    .mem_write_en   (mem_write_en),
    .mem_addr       (mem_addr),
    .mem_write_data (mem_write_data),
    .mem_read_data  (mem_read_data),
    .irq            (irq)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  function automatic logic [3:0] model_read(input logic [11:0] a);
    if (a < `MCU_RAM_END) return shadow_ram[a[9:0]];
    if (a[11:8] != `MCU_IO_PAGE) return 4'h0;
    case (a[7:0])
      `REG_CLK_MASK:  return sh_clk_mask;
      `REG_SW_MASK:   return {2'b00, sh_sw_mask};
      `REG_PT_MASK:   return {3'b000, sh_pt_mask};
      `REG_RELOAD_LO: return sh_reload[3:0];
      `REG_RELOAD_HI: return sh_reload[7:4];
      `REG_PT_SEL:    return {2'b00, sh_pt_src};
      `REG_SVD:       return {1'b1, sh_svd};
      `REG_SW_CTRL:   return {3'b000, sh_sw_en};
      `REG_PT_CTRL:   return {3'b000, sh_pt_en};
      default:        return 4'h0;
    endcase
  endfunction

  // Factors and live counters depend on timing, so no static model
  function automatic bit model_known(input logic [11:0] a);
    if (a[11:8] != `MCU_IO_PAGE) return 1'b1;
    return !((a[7:0] <= `REG_PT_FACTOR) ||
             ((a[7:0] >= `REG_CLK_LO) && (a[7:0] <= `REG_PT_HI)));
  endfunction

  task automatic update_shadow(input logic [11:0] a, input logic [3:0] d);
    if (a < `MCU_RAM_END) begin
      shadow_ram[a[9:0]] = d;
    end else if (a[11:8] == `MCU_IO_PAGE) begin
      case (a[7:0])
        `REG_CLK_MASK:  sh_clk_mask = d;
        `REG_SW_MASK:   sh_sw_mask = d[1:0];
        `REG_PT_MASK:   sh_pt_mask = d[0];
        `REG_RELOAD_LO: sh_reload[3:0] = d;
        `REG_RELOAD_HI: sh_reload[7:4] = d;
        `REG_PT_SEL:    sh_pt_src = d[1:0];
        `REG_SVD:       sh_svd = d[2:0];
        `REG_SW_CTRL:   sh_sw_en = d[0];
        `REG_PT_CTRL:   sh_pt_en = d[0];
        default: ;
      endcase
    end
  endtask

  task automatic check_eq(input logic [3:0] got, input logic [3:0] exp, input string what);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("** Error at time %0t: %s read 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    check_count++;
    assert (cond) else begin
      error_count++;
      $display("** Error at time %0t: %s", $time, what);
    end
  endtask

  task automatic bus_write(input logic [11:0] a, input logic [3:0] d);
    @(negedge clk);
    mem_write_en = 1'b1;
    mem_addr = a;
    mem_write_data = d;
    update_shadow(a, d);
    @(negedge clk);
    mem_write_en = 1'b0;
    mem_addr = idle_addr;
    mem_write_data = 4'h0;
  endtask

  task automatic bus_read(input logic [11:0] a, input bit check, output logic [3:0] data);
    @(negedge clk);
    mem_write_en = 1'b0;
    mem_addr = a;
    rd_addr = a;
    rd_exp = model_read(a);
    rd_check = check && model_known(a);
    rd_issued = 1'b1;
    @(negedge clk);
    data = mem_read_data;
    rd_issued = 1'b0;
    mem_addr = idle_addr;
  endtask

  task automatic wait_irq(input int idx, input logic level, input int limit);
    int n;
    n = 0;
    while (irq[idx] !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (irq[idx] !== level) begin
      error_count++;
      $display("Timeout: irq bit %0d did not reach %0b within %0d cycles", idx, level, limit);
    end
  endtask

  task automatic finish_test(input int num, input string name);
    // Let the compare process settle the last read first
    @(posedge clk);
    if (error_count == err_mark) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: fail, %0d errors", num, name, error_count - err_mark);
    end
    err_mark = error_count;
  endtask

  // Checks the read data one cycle after each modeled read
  initial begin : compare_reads
    logic [3:0] exp;
    logic [11:0] a;
    bit chk;
    forever begin
      @(posedge clk);
      if (rd_issued) begin
        exp = rd_exp;
        a = rd_addr;
        chk = rd_check;
        @(negedge clk);
        if (chk) check_eq(mem_read_data, exp, $sformatf("addr 0x%03h", a));
      end
    end
  end

  initial begin : stimulus
    logic [11:0] a;
    logic [11:0] ram_addrs [$];
    logic [11:0] quiet_addrs [8];
    logic [3:0] v;
    logic [3:0] lo;
    logic [3:0] hi;
    logic [3:0] lo2;
    logic [3:0] hi2;
    logic [7:0] reload_val;
    bit stayed_low;

    void'($urandom(32'h6671));
    quiet_addrs = '{`MCU_DISP_LO_START, `MCU_DISP_LO_END - 12'd1,
                    `MCU_DISP_HI_START, `MCU_DISP_HI_END - 12'd1,
                    12'h300, 12'h7FF, 12'hF70, 12'hF50};
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    check_true(irq == 3'b000, "irq not zero after reset");
    bus_read({`MCU_IO_PAGE, `REG_CLK_MASK}, 1'b1, v);
    bus_read({`MCU_IO_PAGE, `REG_SW_MASK}, 1'b1, v);
    bus_read({`MCU_IO_PAGE, `REG_PT_MASK}, 1'b1, v);
    bus_read({`MCU_IO_PAGE, `REG_SW_CTRL}, 1'b1, v);
    bus_read({`MCU_IO_PAGE, `REG_PT_CTRL}, 1'b1, v);
    for (int i = 0; i < 3; i++) begin
      bus_read({`MCU_IO_PAGE, 8'(i)}, 1'b0, v);
      check_eq(v, 4'h0, $sformatf("factor %0d after reset", i));
    end
    finish_test(1, "reset values");

    for (int i = 0; i < 40; i++) begin
      a = 12'($urandom_range(`MCU_RAM_WORDS - 1));
      bus_write(a, 4'($urandom));
      ram_addrs.push_back(a);
    end
    foreach (ram_addrs[i]) bus_read(ram_addrs[i], 1'b1, v);
    foreach (quiet_addrs[i]) bus_read(quiet_addrs[i], 1'b1, v);
    finish_test(2, "ram and unmapped");

    for (int r = 0; r < 3; r++) begin
      bus_write({`MCU_IO_PAGE, `REG_CLK_MASK}, 4'($urandom));
      bus_write({`MCU_IO_PAGE, `REG_SW_MASK}, 4'($urandom));
      bus_write({`MCU_IO_PAGE, `REG_PT_MASK}, 4'($urandom));
      bus_write({`MCU_IO_PAGE, `REG_RELOAD_LO}, 4'($urandom));
      bus_write({`MCU_IO_PAGE, `REG_RELOAD_HI}, 4'($urandom));
      bus_write({`MCU_IO_PAGE, `REG_PT_SEL}, 4'($urandom));
      bus_write({`MCU_IO_PAGE, `REG_SVD}, 4'($urandom));
      bus_read({`MCU_IO_PAGE, `REG_CLK_MASK}, 1'b1, v);
      bus_read({`MCU_IO_PAGE, `REG_SW_MASK}, 1'b1, v);
      bus_read({`MCU_IO_PAGE, `REG_PT_MASK}, 1'b1, v);
      bus_read({`MCU_IO_PAGE, `REG_RELOAD_LO}, 1'b1, v);
      bus_read({`MCU_IO_PAGE, `REG_RELOAD_HI}, 1'b1, v);
      bus_read({`MCU_IO_PAGE, `REG_PT_SEL}, 1'b1, v);
      bus_read({`MCU_IO_PAGE, `REG_SVD}, 1'b1, v);
    end
    bus_write({`MCU_IO_PAGE, `REG_CLK_MASK}, 4'h0);
    bus_write({`MCU_IO_PAGE, `REG_SW_MASK}, 4'h0);
    bus_write({`MCU_IO_PAGE, `REG_PT_MASK}, 4'h0);
    finish_test(3, "register readback");

    bus_write({`MCU_IO_PAGE, `REG_SW_CTRL}, 4'h1);
    repeat (300) @(negedge clk);
    bus_read({`MCU_IO_PAGE, `REG_SW_LO}, 1'b0, lo);
    bus_read({`MCU_IO_PAGE, `REG_SW_HI}, 1'b0, hi);
    check_true(lo <= 4'd9 && hi <= 4'd9, $sformatf("stopwatch not BCD: %0h%0h", hi, lo));
    check_true({hi, lo} != 8'h00, "stopwatch did not advance");
    bus_write({`MCU_IO_PAGE, `REG_SW_CTRL}, 4'h0);
    bus_read({`MCU_IO_PAGE, `REG_SW_LO}, 1'b0, lo);
    bus_read({`MCU_IO_PAGE, `REG_SW_HI}, 1'b0, hi);
    repeat (50) @(negedge clk);
    bus_read({`MCU_IO_PAGE, `REG_SW_LO}, 1'b0, lo2);
    bus_read({`MCU_IO_PAGE, `REG_SW_HI}, 1'b0, hi2);
    check_eq(lo2, lo, "paused stopwatch low");
    check_eq(hi2, hi, "paused stopwatch high");
    bus_write({`MCU_IO_PAGE, `REG_SW_CTRL}, 4'h2);
    bus_read({`MCU_IO_PAGE, `REG_SW_LO}, 1'b0, v);
    check_eq(v, 4'h0, "stopwatch low after reset");
    bus_read({`MCU_IO_PAGE, `REG_SW_HI}, 1'b0, v);
    check_eq(v, 4'h0, "stopwatch high after reset");
    finish_test(4, "stopwatch");

    reload_val = 8'($urandom_range(15, 2));
    bus_write({`MCU_IO_PAGE, `REG_RELOAD_LO}, reload_val[3:0]);
    bus_write({`MCU_IO_PAGE, `REG_RELOAD_HI}, reload_val[7:4]);
    bus_write({`MCU_IO_PAGE, `REG_PT_SEL}, 4'(PT_SRC_256));
    bus_write({`MCU_IO_PAGE, `REG_PT_CTRL}, 4'h1);
    for (int i = 0; i < 6; i++) begin
      bus_read({`MCU_IO_PAGE, `REG_PT_LO}, 1'b0, lo);
      bus_read({`MCU_IO_PAGE, `REG_PT_HI}, 1'b0, hi);
      check_true({hi, lo} <= reload_val, $sformatf("pt count 0x%02h over reload", {hi, lo}));
    end
    // Drop any stale event so the request follows a fresh one
    bus_read({`MCU_IO_PAGE, `REG_PT_FACTOR}, 1'b0, v);
    bus_write({`MCU_IO_PAGE, `REG_PT_MASK}, 4'h1);
    wait_irq(2, 1'b1, 500);
    bus_read({`MCU_IO_PAGE, `REG_PT_FACTOR}, 1'b0, v);
    check_eq(v, 4'h1, "pt factor first read");
    bus_read({`MCU_IO_PAGE, `REG_PT_FACTOR}, 1'b0, v);
    check_eq(v, 4'h0, "pt factor second read");
    wait_irq(2, 1'b0, 10);
    bus_write({`MCU_IO_PAGE, `REG_PT_CTRL}, 4'h0);
    bus_write({`MCU_IO_PAGE, `REG_PT_MASK}, 4'h0);
    finish_test(5, "programmable timer");

    bus_read({`MCU_IO_PAGE, `REG_CLK_FACTOR}, 1'b0, v);
    bus_write({`MCU_IO_PAGE, `REG_CLK_MASK}, 4'h1);
    wait_irq(0, 1'b1, 200);
    bus_read({`MCU_IO_PAGE, `REG_CLK_FACTOR}, 1'b0, v);
    check_true(v[0], $sformatf("clock factor 0x%0h lacks the 32 Hz bit", v));
    wait_irq(0, 1'b0, 10);
    bus_write({`MCU_IO_PAGE, `REG_CLK_MASK}, 4'h0);
    @(negedge clk);
    stayed_low = 1'b1;
    repeat (600) begin
      @(negedge clk);
      if (irq != 3'b000) stayed_low = 1'b0;
    end
    check_true(stayed_low, "irq rose with all masks zero");
    bus_read({`MCU_IO_PAGE, `REG_CLK_FACTOR}, 1'b0, v);
    check_true(v != 4'h0, "clock factor not set while masked");
    finish_test(6, "clock interrupt");

    $display("%0d tests, %0d failed, %0d checks, %0d errors", 6, failed_tests, check_count,
             error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
